// ==== filelist.f ====
+incdir+include
verilog/exec_pkg.sv
verilog/exec_regfile_ff.sv
verilog/exec_instr_decoder.sv
verilog/exec_alu_writeback.sv
verilog/exec_core_top.sv
tests/exec_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the execute unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module exec_core_tb -o exec_core_sim > build.log 2>&1 \
  && { ./obj_dir/exec_core_sim > sim.log 2>&1 || true; } \
  || { cat build.log; echo "Build failed"; exit 1; }

cat sim.log
grep -q "Errors found" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "No errors" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation PASSED"

// ==== include/exec_test_table.svh ====
/*
 * Stimulus table for the execute unit testbench, included inside its module.
 * Each row holds an instruction word with its expected rd, result and illegal flag.
 */
`ifndef EXEC_TEST_TABLE_SVH
`define EXEC_TEST_TABLE_SVH

typedef struct packed {
  exec_pkg::instr_t    instr;
  exec_pkg::reg_addr_t rd;
  exec_pkg::word_t     result;
  logic                illegal;
} test_row_t;

localparam int unsigned TEST_ROWS = 21;

localparam test_row_t TEST_TABLE [TEST_ROWS] = '{
  // Load operands with ADDI
  '{32'h00500093, 5'd1,  32'h00000005, 1'b0},  // addi x1, x0, 5
  '{32'hFFD00113, 5'd2,  32'hFFFFFFFD, 1'b0},  // addi x2, x0, -3
  '{32'h0F000193, 5'd3,  32'h000000F0, 1'b0},  // addi x3, x0, 0xf0
  // Register-register forms
  '{32'h00208233, 5'd4,  32'h00000002, 1'b0},  // add  x4, x1, x2
  '{32'h402082B3, 5'd5,  32'h00000008, 1'b0},  // sub  x5, x1, x2
  '{32'h0021F333, 5'd6,  32'h000000F0, 1'b0},  // and  x6, x3, x2
  '{32'h0011E3B3, 5'd7,  32'h000000F5, 1'b0},  // or   x7, x3, x1
  '{32'h0033C433, 5'd8,  32'h00000005, 1'b0},  // xor  x8, x7, x3 reads x7 at once
  '{32'h004094B3, 5'd9,  32'h00000014, 1'b0},  // sll  x9, x1, x4
  '{32'h00415533, 5'd10, 32'h3FFFFFFF, 1'b0},  // srl  x10, x2, x4
  '{32'h001125B3, 5'd11, 32'h00000001, 1'b0},  // slt  x11, x2, x1
  '{32'h0020A633, 5'd12, 32'h00000000, 1'b0},  // slt  x12, x1, x2
  // Immediate forms
  '{32'h07F17693, 5'd13, 32'h0000007D, 1'b0},  // andi x13, x2, 0x7f
  '{32'h1000E713, 5'd14, 32'h00000105, 1'b0},  // ori  x14, x1, 0x100
  '{32'hFFF74793, 5'd15, 32'hFFFFFEFA, 1'b0},  // xori x15, x14, -1
  // R0 write is reported but not stored
  '{32'h00708013, 5'd0,  32'h0000000C, 1'b0},  // addi x0, x1, 7
  '{32'h00100233, 5'd4,  32'h00000005, 1'b0},  // add  x4, x0, x1
  // Illegal encodings leave rd untouched
  '{32'h0020B2B3, 5'd5,  32'h00000000, 1'b1},  // sltu x5, x1, x2 is not supported
  '{32'h0000A303, 5'd6,  32'h00000000, 1'b1},  // lw   x6, 0(x1) has a load opcode
  '{32'h00028393, 5'd7,  32'h00000008, 1'b0},  // addi x7, x5, 0
  '{32'h00030433, 5'd8,  32'h000000F0, 1'b0}   // add  x8, x6, x0
};

`endif

// ==== tests/exec_core_tb.sv ====
/*
 * Testbench for the execute unit top level.
 * Sends the table rows under upstream credits, returns result credits after
 * random delays and checks every result in order against the table.
 */
`timescale 1ns/1ns

module exec_core_tb;

  `include "exec_test_table.svh"

  localparam int unsigned InstrDepth    = 4;
  localparam int unsigned ResultCredits = 2;
  localparam int          TimeoutCycles = 200;

  logic                clk_i = 1'b0;
  logic                rst_n;
  logic                instr_valid;
  exec_pkg::instr_t    instr;
  logic                instr_credit;
  logic                res_valid;
  exec_pkg::word_t     res_data;
  exec_pkg::reg_addr_t res_rd;
  logic                res_illegal;
  logic                res_credit;
  logic                err;

  // Expected results in issue order
  test_row_t scoreboard [$];

  int  sent          = 0;
  int  credit_pulses = 0;
  int  results_seen  = 0;
  int  outstanding   = 0;
  int  delay_left    = 0;
  bit  hold_credits  = 1'b1;

  exec_core_top #(
    .InstrDepth    (InstrDepth),
    .ResultCredits (ResultCredits),
    .Rv32e         (1'b0)
  ) UUT (
    .clk_i          (clk_i),
    .rst_ni         (rst_n),
    .instr_valid_i  (instr_valid),
    .instr_i        (instr),
    .instr_credit_o (instr_credit),
    .res_valid_o    (res_valid),
    .res_data_o     (res_data),
    .res_rd_o       (res_rd),
    .res_illegal_o  (res_illegal),
    .res_credit_i   (res_credit),
    .err_o          (err)
  );

  always #10 clk_i = ~clk_i;

  task automatic end_in_failure();
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
    if (actual !== expected) begin
      $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      end_in_failure();
    end
  endtask

  // Outputs are sampled at the falling edge where they are stable
  always @(negedge clk_i) begin
    test_row_t exp_row;
    if (rst_n) begin
      compare(32'(err), 32'd0, "register file strobe error");
      if (instr_credit) begin
        credit_pulses++;
        if (credit_pulses > sent) begin
          $display("More upstream credits returned than instructions sent");
          end_in_failure();
        end
      end
      if (res_valid) begin
        if (scoreboard.size() == 0) begin
          $display("Result arrived with no instruction outstanding");
          end_in_failure();
        end
        exp_row = scoreboard.pop_front();
        compare(32'(res_rd), 32'(exp_row.rd), "result destination");
        compare(32'(res_illegal), 32'(exp_row.illegal), "illegal flag");
        compare(res_data, exp_row.result, "result data");
        results_seen++;
        outstanding++;
        compare(32'(outstanding <= int'(ResultCredits)), 32'd1, "outstanding results bound");
      end
    end
  end

  // Downstream credit return with a random gap between pulses
  initial begin
    void'($urandom(32'h797e6237));
    res_credit = 1'b0;
    forever begin
      @(posedge clk_i);
      #2;
      res_credit = 1'b0;
      if (rst_n && !hold_credits && outstanding > 0) begin
        if (delay_left == 0) begin
          res_credit = 1'b1;
          outstanding--;
          delay_left = int'($urandom % 6);
        end else begin
          delay_left--;
        end
      end
    end
  end

  initial begin
    int idx;
    int wait_cycles;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    idx         = 0;
    wait_cycles = 0;

    repeat (16) @(posedge clk_i);
    #2;
    rst_n = 1'b1;

    // Quiet outputs straight after reset
    @(negedge clk_i);
    compare(32'(instr_credit), 32'd0, "instr_credit_o after reset");
    compare(32'(res_valid), 32'd0, "res_valid_o after reset");
    compare(32'(err), 32'd0, "err_o after reset");

    // Send rows back to back while upstream credits last
    while (idx < int'(TEST_ROWS)) begin
      @(posedge clk_i);
      #2;
      if (sent - credit_pulses < int'(InstrDepth)) begin
        instr_valid = 1'b1;
        instr       = TEST_TABLE[idx].instr;
        scoreboard.push_back(TEST_TABLE[idx]);
        sent++;
        idx++;
        wait_cycles = 0;
      end else begin
        instr_valid = 1'b0;
        wait_cycles++;
        // Withheld credits stall the core after ResultCredits results
        if (hold_credits && wait_cycles == 8) begin
          compare(results_seen, ResultCredits, "results delivered while credits withheld");
          @(negedge clk_i);
          hold_credits = 1'b0;
        end
        if (wait_cycles > TimeoutCycles) begin
          $display("Timeout: upstream credits stopped coming back from the core");
          end_in_failure();
        end
      end
    end
    @(posedge clk_i);
    #2;
    instr_valid = 1'b0;

    // Drain every result
    wait_cycles = 0;
    while (results_seen < int'(TEST_ROWS)) begin
      @(posedge clk_i);
      wait_cycles++;
      if (wait_cycles > TimeoutCycles) begin
        $display("Timeout: the core stopped delivering results");
        end_in_failure();
      end
    end

    // Let the last downstream credits go back
    wait_cycles = 0;
    while (outstanding > 0) begin
      @(posedge clk_i);
      wait_cycles++;
      if (wait_cycles > TimeoutCycles) begin
        $display("Timeout: downstream credits were never returned");
        end_in_failure();
      end
    end

    compare(credit_pulses, sent, "upstream credit pulses");
    $display("No errors");
    $finish;
  end

endmodule

// ==== verilog/exec_core_top.sv ====
/*
 * Top level of the execute unit.
 * Connects the instruction decoder, register file and ALU/writeback stage.
 */
`timescale 1ns/1ns

module exec_core_top #(
  parameter int unsigned InstrDepth    = 4,
  parameter int unsigned ResultCredits = 2,
  parameter bit          Rv32e         = 1'b0
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                instr_valid_i,
  input  exec_pkg::instr_t    instr_i,
  output logic                instr_credit_o,
  output logic                res_valid_o,
  output exec_pkg::word_t     res_data_o,
  output exec_pkg::reg_addr_t res_rd_o,
  output logic                res_illegal_o,
  input  logic                res_credit_i,
  output logic                err_o
);

  // Decoded head of the queue
  logic                head_valid;
  exec_pkg::reg_addr_t raddr_a;
  exec_pkg::reg_addr_t raddr_b;
  exec_pkg::reg_addr_t rd;
  exec_pkg::alu_op_e   alu_op;
  exec_pkg::word_t     imm;
  logic                use_imm;
  logic                illegal;
  logic                issue;

  // Register file ports
  exec_pkg::word_t     rdata_a;
  exec_pkg::word_t     rdata_b;
  logic                we;
  exec_pkg::reg_addr_t waddr;
  exec_pkg::word_t     wdata;

  exec_instr_decoder #(
    .InstrDepth(InstrDepth)
  ) u_decoder (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .instr_credit_o (instr_credit_o),
    .issue_i        (issue),
    .head_valid_o   (head_valid),
    .raddr_a_o      (raddr_a),
    .raddr_b_o      (raddr_b),
    .rd_o           (rd),
    .alu_op_o       (alu_op),
    .imm_o          (imm),
    .use_imm_o      (use_imm),
    .illegal_o      (illegal)
  );

  exec_regfile_ff #(
    .Rv32e(Rv32e)
  ) u_regfile (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (raddr_a),
    .raddr_b_i (raddr_b),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .waddr_i   (waddr),
    .wdata_i   (wdata),
    .we_i      (we),
    .err_o     (err_o)
  );

  exec_alu_writeback #(
    .ResultCredits(ResultCredits)
  ) u_alu_wb (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .head_valid_i  (head_valid),
    .alu_op_i      (alu_op),
    .imm_i         (imm),
    .use_imm_i     (use_imm),
    .illegal_i     (illegal),
    .rd_i          (rd),
    .rdata_a_i     (rdata_a),
    .rdata_b_i     (rdata_b),
    .issue_o       (issue),
    .we_o          (we),
    .waddr_o       (waddr),
    .wdata_o       (wdata),
    .res_credit_i  (res_credit_i),
    .res_valid_o   (res_valid_o),
    .res_data_o    (res_data_o),
    .res_rd_o      (res_rd_o),
    .res_illegal_o (res_illegal_o)
  );

endmodule

// ==== verilog/exec_alu_writeback.sv ====
/*
 * ALU and writeback stage with the downstream credit counter.
 * Issues the queue head when a credit is free, writes the register file
 * on the same edge and presents the result one cycle later.
 */
`timescale 1ns/1ns

module exec_alu_writeback #(
  parameter int unsigned ResultCredits = 2
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                head_valid_i,
  input  exec_pkg::alu_op_e   alu_op_i,
  input  exec_pkg::word_t     imm_i,
  input  logic                use_imm_i,
  input  logic                illegal_i,
  input  exec_pkg::reg_addr_t rd_i,
  input  exec_pkg::word_t     rdata_a_i,
  input  exec_pkg::word_t     rdata_b_i,
  output logic                issue_o,
  output logic                we_o,
  output exec_pkg::reg_addr_t waddr_o,
  output exec_pkg::word_t     wdata_o,
  input  logic                res_credit_i,
  output logic                res_valid_o,
  output exec_pkg::word_t     res_data_o,
  output exec_pkg::reg_addr_t res_rd_o,
  output logic                res_illegal_o
);

  localparam int unsigned CreditWidth = $clog2(ResultCredits + 1);

  logic [CreditWidth-1:0] credit_q;
  exec_pkg::word_t        op_a;
  exec_pkg::word_t        op_b;
  logic [4:0]             shamt;
  exec_pkg::word_t        alu_result;

  // Operand B from immediate for OP-IMM
  assign op_a  = rdata_a_i;
  assign op_b  = use_imm_i ? imm_i : rdata_b_i;
  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op_i)
      exec_pkg::ALU_ADD: alu_result = op_a + op_b;
      exec_pkg::ALU_SUB: alu_result = op_a - op_b;
      exec_pkg::ALU_AND: alu_result = op_a & op_b;
      exec_pkg::ALU_OR:  alu_result = op_a | op_b;
      exec_pkg::ALU_XOR: alu_result = op_a ^ op_b;
      exec_pkg::ALU_SLL: alu_result = op_a << shamt;
      exec_pkg::ALU_SRL: alu_result = op_a >> shamt;
      exec_pkg::ALU_SLT: begin
        alu_result = {{(exec_pkg::DATA_WIDTH - 1){1'b0}}, $signed(op_a) < $signed(op_b)};
      end
      default:           alu_result = '0;
    endcase
  end

  // Issue needs a valid head and a free downstream credit
  assign issue_o = head_valid_i && (credit_q != '0);

  // Write lands on the edge that ends the issue cycle
  assign we_o    = issue_o && !illegal_i;
  assign waddr_o = rd_i;
  assign wdata_o = alu_result;

  // Spend on issue, refill on returned credit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= CreditWidth'(ResultCredits);
    end else if (issue_o && !res_credit_i) begin
      credit_q <= credit_q - 1'b1;
    end else if (!issue_o && res_credit_i) begin
      credit_q <= credit_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= issue_o;
    end
  end

  // Illegal entries report zero data
  always_ff @(posedge clk_i) begin
    if (issue_o) begin
      res_data_o    <= illegal_i ? '0 : alu_result;
      res_rd_o      <= rd_i;
      res_illegal_o <= illegal_i;
    end
  end

  // Downstream may only return credits it was given
  a_credit_bound: assert property (
    @(posedge clk_i) disable iff (!rst_ni) credit_q <= CreditWidth'(ResultCredits)
  ) else $error("Downstream credit counter above its initial value");

endmodule

// ==== verilog/exec_instr_decoder.sv ====
/*
 * Instruction queue with upstream credit return and decode of the head entry.
 * The head fields stay valid until the writeback stage issues the entry.
 */
`timescale 1ns/1ns

module exec_instr_decoder #(
  parameter int unsigned InstrDepth = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                instr_valid_i,
  input  exec_pkg::instr_t    instr_i,
  output logic                instr_credit_o,
  input  logic                issue_i,
  output logic                head_valid_o,
  output exec_pkg::reg_addr_t raddr_a_o,
  output exec_pkg::reg_addr_t raddr_b_o,
  output exec_pkg::reg_addr_t rd_o,
  output exec_pkg::alu_op_e   alu_op_o,
  output exec_pkg::word_t     imm_o,
  output logic                use_imm_o,
  output logic                illegal_o
);

  localparam int unsigned PtrWidth = (InstrDepth > 1) ? $clog2(InstrDepth) : 1;
  localparam int unsigned CntWidth = $clog2(InstrDepth + 1);

  exec_pkg::instr_t    queue_q [InstrDepth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  exec_pkg::instr_t    head;
  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;

  // Queue storage
  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      queue_q[wr_ptr_q] <= instr_i;
    end
  end

  // Pointers wrap at the queue depth
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (instr_valid_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(InstrDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (issue_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(InstrDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (instr_valid_i && !issue_i) begin
        count_q <= count_q + 1'b1;
      end else if (!instr_valid_i && issue_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Each pop frees one entry, handed back as a credit
  assign instr_credit_o = issue_i;
  assign head_valid_o   = (count_q != '0);

  // Head fields in RV32I layout
  assign head      = queue_q[rd_ptr_q];
  assign opcode    = head[6:0];
  assign rd_o      = head[11:7];
  assign funct3    = head[14:12];
  assign raddr_a_o = head[19:15];
  assign raddr_b_o = head[24:20];
  assign funct7    = head[31:25];
  // Sign-extended I-type immediate
  assign imm_o     = {{(exec_pkg::DATA_WIDTH - 12){head[31]}}, head[31:20]};

  always_comb begin
    alu_op_o  = exec_pkg::ALU_ADD;
    use_imm_o = 1'b0;
    illegal_o = 1'b0;
    case (opcode)
      exec_pkg::OPC_OP: begin
        if (funct7 == exec_pkg::F7_BASE) begin
          case (funct3)
            exec_pkg::F3_ADD_SUB: alu_op_o = exec_pkg::ALU_ADD;
            exec_pkg::F3_SLL:     alu_op_o = exec_pkg::ALU_SLL;
            exec_pkg::F3_SLT:     alu_op_o = exec_pkg::ALU_SLT;
            exec_pkg::F3_XOR:     alu_op_o = exec_pkg::ALU_XOR;
            exec_pkg::F3_SRL:     alu_op_o = exec_pkg::ALU_SRL;
            exec_pkg::F3_OR:      alu_op_o = exec_pkg::ALU_OR;
            exec_pkg::F3_AND:     alu_op_o = exec_pkg::ALU_AND;
            default:              illegal_o = 1'b1;
          endcase
        end else if (funct7 == exec_pkg::F7_ALT && funct3 == exec_pkg::F3_ADD_SUB) begin
          alu_op_o = exec_pkg::ALU_SUB;
        end else begin
          illegal_o = 1'b1;
        end
      end
      exec_pkg::OPC_OP_IMM: begin
        use_imm_o = 1'b1;
        case (funct3)
          exec_pkg::F3_ADD_SUB: alu_op_o = exec_pkg::ALU_ADD;
          exec_pkg::F3_XOR:     alu_op_o = exec_pkg::ALU_XOR;
          exec_pkg::F3_OR:      alu_op_o = exec_pkg::ALU_OR;
          exec_pkg::F3_AND:     alu_op_o = exec_pkg::ALU_AND;
          default:              illegal_o = 1'b1;
        endcase
      end
      // Loads, stores, branches and the rest
      default: illegal_o = 1'b1;
    endcase
  end

  // Upstream must respect its credits
  a_no_push_when_full: assert property (
    @(posedge clk_i) disable iff (!rst_ni) instr_valid_i |-> (count_q != CntWidth'(InstrDepth))
  ) else $error("Instruction pushed into a full queue");

  a_no_issue_when_empty: assert property (
    @(posedge clk_i) disable iff (!rst_ni) issue_i |-> head_valid_o
  ) else $error("Issue while the instruction queue is empty");

endmodule

// ==== verilog/exec_regfile_ff.sv ====
/*
 * Flip-flop register file, two combinational read ports and one write port.
 * Register 0 reads as zero; err_o flags inconsistent write strobes.
 */
`timescale 1ns/1ns

module exec_regfile_ff #(
  parameter bit Rv32e = 1'b0
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  exec_pkg::reg_addr_t raddr_a_i,
  input  exec_pkg::reg_addr_t raddr_b_i,
  output exec_pkg::word_t     rdata_a_o,
  output exec_pkg::word_t     rdata_b_o,
  input  exec_pkg::reg_addr_t waddr_i,
  input  exec_pkg::word_t     wdata_i,
  input  logic                we_i,
  output logic                err_o
);

  // RV32E keeps 16 registers on the low 4 address bits
  localparam int unsigned AddrWidth = Rv32e ? 4 : 5;
  localparam int unsigned NumRegs   = 2 ** AddrWidth;

  exec_pkg::word_t      rf_reg [NumRegs];
  logic [NumRegs-1:0]   we_dec;
  logic [AddrWidth-1:0] waddr_eff;
  logic [AddrWidth-1:0] strobe_addr;
  logic                 strobe_any;
  logic                 strobe_multi;

  assign waddr_eff = waddr_i[AddrWidth-1:0];

  // One strobe per register including the unused R0 slot
  always_comb begin
    for (int unsigned i = 0; i < NumRegs; i++) begin
      we_dec[i] = we_i && (waddr_eff == AddrWidth'(i));
    end
  end

  // Re-encode the strobes to compare against the write address
  always_comb begin
    strobe_addr = '0;
    for (int unsigned i = 0; i < NumRegs; i++) begin
      if (we_dec[i]) begin
        strobe_addr = strobe_addr | AddrWidth'(i);
      end
    end
  end

  assign strobe_any   = |we_dec;
  // Any bit left after clearing the lowest set bit means more than one strobe
  assign strobe_multi = |(we_dec & (we_dec - NumRegs'(1)));

  // Error on multiple strobes, enable mismatch or address mismatch
  assign err_o = strobe_multi || (strobe_any != we_i) ||
                 (strobe_any && (strobe_addr != waddr_eff));

  // R0 has no storage
  assign rf_reg[0] = '0;

  for (genvar i = 1; i < NumRegs; i++) begin : g_rf_flops
    exec_pkg::word_t rf_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rf_q <= '0;
      end else if (we_dec[i]) begin
        rf_q <= wdata_i;
      end
    end

    assign rf_reg[i] = rf_q;
  end

  // Combinational reads
  assign rdata_a_o = rf_reg[raddr_a_i[AddrWidth-1:0]];
  assign rdata_b_o = rf_reg[raddr_b_i[AddrWidth-1:0]];

endmodule

// ==== verilog/exec_pkg.sv ====
/*
 * Shared widths, types and encodings of the integer execute unit.
 * RTL and testbench refer to these by scoped names.
 */
package exec_pkg;

  // Data path width
  parameter int unsigned DATA_WIDTH = 32;

  typedef logic [DATA_WIDTH-1:0] word_t;
  typedef logic [31:0]           instr_t;
  typedef logic [4:0]            reg_addr_t;

  // Operations the ALU can perform
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SLT
  } alu_op_e;

  // Major opcodes, RV32I encoding
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // funct3 field values
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL     = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7 field values
  // Alternate form selects SUB
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage
